/* common/isaPkg.sv */
package isaPkg;

    localparam int wordW = 32;
    localparam int regIdxW = 5;
    localparam int opcodeW = 6;
    localparam int functW = 6;

    localparam logic [regIdxW-1:0] linkReg = 5'd31; // $ra

    // primary opcodes
    localparam logic [opcodeW-1:0]
        opSpecial = 6'h00, opRegimm = 6'h01, opJ = 6'h02, opJal = 6'h03,
        opBeq = 6'h04, opBne = 6'h05, opBlez = 6'h06, opBgtz = 6'h07,
        opAddi = 6'h08, opAddiu = 6'h09, opSlti = 6'h0a, opSltiu = 6'h0b,
        opAndi = 6'h0c, opOri = 6'h0d, opXori = 6'h0e, opLui = 6'h0f,
        opBeql = 6'h14, opBnel = 6'h15, opBlezl = 6'h16, opBgtzl = 6'h17,
        opLb = 6'h20, opLh = 6'h21, opLw = 6'h23, opLbu = 6'h24,
        opLhu = 6'h25, opSb = 6'h28, opSh = 6'h29, opSw = 6'h2b;

    // SPECIAL funct codes
    localparam logic [functW-1:0]
        fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03,
        fnSllv = 6'h04, fnSrlv = 6'h06, fnSrav = 6'h07,
        fnJr = 6'h08, fnJalr = 6'h09,
        fnAdd = 6'h20, fnAddu = 6'h21, fnSub = 6'h22, fnSubu = 6'h23,
        fnAnd = 6'h24, fnOr = 6'h25, fnXor = 6'h26, fnNor = 6'h27,
        fnSlt = 6'h2a, fnSltu = 6'h2b;

    // REGIMM rt codes with link in bit 4, likely in bit 1 and gez in bit 0
    localparam logic [regIdxW-1:0]
        rimmBltz = 5'h00, rimmBgez = 5'h01, rimmBltzl = 5'h02, rimmBgezl = 5'h03,
        rimmBltzal = 5'h10, rimmBgezal = 5'h11,
        rimmBltzall = 5'h12, rimmBgezall = 5'h13;

    typedef union packed {
        struct packed {
            logic [opcodeW-1:0] opcode;
            logic [regIdxW-1:0] rs;
            logic [regIdxW-1:0] rt;
            logic [regIdxW-1:0] rd;
            logic [regIdxW-1:0] shamt;
            logic [functW-1:0] funct;
        } rView;
        struct packed {
            logic [opcodeW-1:0] opcode;
            logic [regIdxW-1:0] rs;
            logic [regIdxW-1:0] rt;
            logic [15:0] imm16;
        } iView;
        struct packed {
            logic [opcodeW-1:0] opcode;
            logic [25:0] target26;
        } jView;
    } instrWord_t;

endpackage

/* common/ctrlPkg.sv */
package ctrlPkg;

    localparam int aluOpW = 4;
    localparam int cmpOpW = 3;
    localparam int grfSrcW = 2;
    localparam int memWidthW = 2;
    localparam int immKindW = 3;

    localparam logic [aluOpW-1:0]
        aluAdd = 4'd0, aluSub = 4'd1, aluAnd = 4'd2, aluOr = 4'd3,
        aluNor = 4'd4, aluXor = 4'd5, aluSll = 4'd6, aluSrl = 4'd7,
        aluSra = 4'd8, aluSlt = 4'd9, aluSltu = 4'd10;

    // 0 means no comparison
    localparam logic [cmpOpW-1:0]
        cmpEq = 3'd1, cmpNe = 3'd2, cmpLtz = 3'd3,
        cmpGez = 3'd4, cmpLez = 3'd5, cmpGtz = 3'd6;

    // register file write source
    localparam logic [grfSrcW-1:0]
        grfNone = 2'd0, grfAlu = 2'd1, grfMem = 2'd2, grfPc = 2'd3;

    localparam logic [memWidthW-1:0]
        memW1 = 2'd1, memW2 = 2'd2, memW4 = 2'd3;

    localparam logic [immKindW-1:0]
        immNone = 3'd0, immSign = 3'd1, immZero = 3'd2,
        immUpper = 3'd3, immShamt = 3'd4, immTarget = 3'd5;

endpackage

/* decoder/specialDecode.sv */
`timescale 1ns/1ps

module specialDecode (
    input  isaPkg::instrWord_t instr,
    output logic [isaPkg::regIdxW-1:0] regRead1,
    output logic [isaPkg::regIdxW-1:0] regRead2,
    output logic [isaPkg::regIdxW-1:0] destReg,
    output logic [ctrlPkg::grfSrcW-1:0] grfSrc,
    output logic [ctrlPkg::aluOpW-1:0] aluOp,
    output logic aluSrc,
    output logic [ctrlPkg::immKindW-1:0] immKind,
    output logic absJump,
    output logic jumpFromReg,
    output logic checkOverflow,
    output logic unknownInstr
);

    logic isArith;
    logic isShiftImm;
    logic isShiftVar;
    logic isJump;

    assign isArith = instr.rView.funct inside {isaPkg::fnAdd, isaPkg::fnAddu,
        isaPkg::fnSub, isaPkg::fnSubu, isaPkg::fnAnd, isaPkg::fnOr, isaPkg::fnNor,
        isaPkg::fnXor, isaPkg::fnSlt, isaPkg::fnSltu};
    assign isShiftImm = instr.rView.funct inside {isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra};
    assign isShiftVar = instr.rView.funct inside {isaPkg::fnSllv, isaPkg::fnSrlv, isaPkg::fnSrav};
    assign isJump = instr.rView.funct inside {isaPkg::fnJr, isaPkg::fnJalr};

    always_comb
    begin
        aluOp = ctrlPkg::aluAdd;
        case (instr.rView.funct)
            isaPkg::fnSub, isaPkg::fnSubu: aluOp = ctrlPkg::aluSub;
            isaPkg::fnAnd:                 aluOp = ctrlPkg::aluAnd;
            isaPkg::fnOr:                  aluOp = ctrlPkg::aluOr;
            isaPkg::fnNor:                 aluOp = ctrlPkg::aluNor;
            isaPkg::fnXor:                 aluOp = ctrlPkg::aluXor;
            isaPkg::fnSlt:                 aluOp = ctrlPkg::aluSlt;
            isaPkg::fnSltu:                aluOp = ctrlPkg::aluSltu;
            isaPkg::fnSll, isaPkg::fnSllv: aluOp = ctrlPkg::aluSll;
            isaPkg::fnSrl, isaPkg::fnSrlv: aluOp = ctrlPkg::aluSrl;
            isaPkg::fnSra, isaPkg::fnSrav: aluOp = ctrlPkg::aluSra;
            default:                       aluOp = ctrlPkg::aluAdd;
        endcase
    end

    // shifts read rt and take a variable amount from rs
    assign regRead1 = (isArith || isJump) ? instr.rView.rs :
                      (isShiftImm || isShiftVar) ? instr.rView.rt : '0;
    assign regRead2 = isArith ? instr.rView.rt :
                      isShiftVar ? instr.rView.rs : '0;

    assign destReg = (isArith || isShiftImm || isShiftVar || instr.rView.funct == isaPkg::fnJalr)
                     ? instr.rView.rd : '0; // jalr links to rd
    assign grfSrc = (instr.rView.funct == isaPkg::fnJalr) ? ctrlPkg::grfPc :
                    (isArith || isShiftImm || isShiftVar) ? ctrlPkg::grfAlu : ctrlPkg::grfNone;

    assign aluSrc = isShiftImm;
    assign immKind = isShiftImm ? ctrlPkg::immShamt : ctrlPkg::immNone;
    assign absJump = isJump;
    assign jumpFromReg = isJump;
    assign checkOverflow = instr.rView.funct inside {isaPkg::fnAdd, isaPkg::fnSub};
    assign unknownInstr = !(isArith || isShiftImm || isShiftVar || isJump);

endmodule

/* decoder/regimmDecode.sv */
`timescale 1ns/1ps

module regimmDecode (
    input  isaPkg::instrWord_t instr,
    output logic [isaPkg::regIdxW-1:0] regRead1,
    output logic [isaPkg::regIdxW-1:0] destReg,
    output logic [ctrlPkg::grfSrcW-1:0] grfSrc,
    output logic [ctrlPkg::immKindW-1:0] immKind,
    output logic [ctrlPkg::cmpOpW-1:0] cmpOp,
    output logic branch,
    output logic branchLikely,
    output logic unknownInstr
);

    logic known;
    logic link;

    assign known = instr.iView.rt inside {isaPkg::rimmBltz, isaPkg::rimmBgez,
        isaPkg::rimmBltzl, isaPkg::rimmBgezl, isaPkg::rimmBltzal, isaPkg::rimmBgezal,
        isaPkg::rimmBltzall, isaPkg::rimmBgezall};
    assign link = known && instr.iView.rt[4];

    assign regRead1 = known ? instr.iView.rs : '0;
    assign destReg = link ? isaPkg::linkReg : '0;
    assign grfSrc = link ? ctrlPkg::grfPc : ctrlPkg::grfNone; // return address
    assign immKind = known ? ctrlPkg::immSign : ctrlPkg::immNone;
    assign cmpOp = !known ? '0 :
                   instr.iView.rt[0] ? ctrlPkg::cmpGez : ctrlPkg::cmpLtz;
    assign branch = known;
    assign branchLikely = known && instr.iView.rt[1];
    assign unknownInstr = !known;

endmodule

/* decoder/primaryDecode.sv */
`timescale 1ns/1ps

module primaryDecode (
    input  isaPkg::instrWord_t instr,
    output logic isSpecial,
    output logic isRegimm,
    output logic [isaPkg::regIdxW-1:0] regRead1,
    output logic [isaPkg::regIdxW-1:0] regRead2,
    output logic [isaPkg::regIdxW-1:0] destReg,
    output logic [ctrlPkg::grfSrcW-1:0] grfSrc,
    output logic [ctrlPkg::aluOpW-1:0] aluOp,
    output logic aluSrc,
    output logic [ctrlPkg::immKindW-1:0] immKind,
    output logic [ctrlPkg::cmpOpW-1:0] cmpOp,
    output logic branch,
    output logic branchLikely,
    output logic absJump,
    output logic jumpFromReg,
    output logic memLoad,
    output logic memStore,
    output logic [ctrlPkg::memWidthW-1:0] memWidth,
    output logic memSignExtend,
    output logic checkOverflow,
    output logic unknownInstr
);

    logic [isaPkg::opcodeW-1:0] op;

    assign op = instr.iView.opcode;

    always_comb
    begin
        isSpecial = 1'b0;
        isRegimm = 1'b0;
        regRead1 = '0;
        regRead2 = '0;
        destReg = '0;
        grfSrc = ctrlPkg::grfNone;
        aluOp = ctrlPkg::aluAdd;
        aluSrc = 1'b0;
        immKind = ctrlPkg::immNone;
        cmpOp = '0;
        branch = 1'b0;
        absJump = 1'b0;
        jumpFromReg = 1'b0; // only SPECIAL jumps use a register
        memLoad = 1'b0;
        memStore = 1'b0;
        memWidth = '0;
        memSignExtend = 1'b0;
        checkOverflow = 1'b0;
        unknownInstr = 1'b0;

        case (op)
            isaPkg::opSpecial: isSpecial = 1'b1;
            isaPkg::opRegimm:  isRegimm = 1'b1;
            isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti, isaPkg::opSltiu,
            isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opLui:
            begin
                regRead1 = instr.iView.rs;
                destReg = instr.iView.rt;
                grfSrc = ctrlPkg::grfAlu;
                aluSrc = 1'b1;
                immKind = (op inside {isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori})
                          ? ctrlPkg::immZero
                          : (op == isaPkg::opLui) ? ctrlPkg::immUpper : ctrlPkg::immSign;
                checkOverflow = (op == isaPkg::opAddi);
            end
            isaPkg::opLb, isaPkg::opLh, isaPkg::opLw, isaPkg::opLbu, isaPkg::opLhu:
            begin
                regRead1 = instr.iView.rs;
                destReg = instr.iView.rt;
                grfSrc = ctrlPkg::grfMem;
                aluSrc = 1'b1; // address = rs + offset
                immKind = ctrlPkg::immSign;
                memLoad = 1'b1;
                memSignExtend = (op inside {isaPkg::opLb, isaPkg::opLh});
                checkOverflow = 1'b1;
            end
            isaPkg::opSb, isaPkg::opSh, isaPkg::opSw:
            begin
                regRead1 = instr.iView.rs;
                regRead2 = instr.iView.rt;
                aluSrc = 1'b1;
                immKind = ctrlPkg::immSign;
                memStore = 1'b1;
                checkOverflow = 1'b1;
            end
            isaPkg::opBeq, isaPkg::opBne, isaPkg::opBeql, isaPkg::opBnel,
            isaPkg::opBlez, isaPkg::opBgtz, isaPkg::opBlezl, isaPkg::opBgtzl:
            begin
                regRead1 = instr.iView.rs;
                regRead2 = op[1] ? '0 : instr.iView.rt; // blez/bgtz compare rs alone
                branch = 1'b1;
                immKind = ctrlPkg::immSign;
            end
            isaPkg::opJ, isaPkg::opJal:
            begin
                absJump = 1'b1;
                immKind = ctrlPkg::immTarget;
                if (op == isaPkg::opJal)
                begin
                    grfSrc = ctrlPkg::grfPc;
                    destReg = isaPkg::linkReg;
                end
            end
            default: unknownInstr = 1'b1;
        endcase

        case (op)
            isaPkg::opSlti:                              aluOp = ctrlPkg::aluSlt;
            isaPkg::opSltiu:                             aluOp = ctrlPkg::aluSltu;
            isaPkg::opAndi:                              aluOp = ctrlPkg::aluAnd;
            isaPkg::opOri:                               aluOp = ctrlPkg::aluOr;
            isaPkg::opXori:                              aluOp = ctrlPkg::aluXor;
            isaPkg::opLb, isaPkg::opLbu, isaPkg::opSb:   memWidth = ctrlPkg::memW1;
            isaPkg::opLh, isaPkg::opLhu, isaPkg::opSh:   memWidth = ctrlPkg::memW2;
            isaPkg::opLw, isaPkg::opSw:                  memWidth = ctrlPkg::memW4;
            isaPkg::opBeq, isaPkg::opBeql:               cmpOp = ctrlPkg::cmpEq;
            isaPkg::opBne, isaPkg::opBnel:               cmpOp = ctrlPkg::cmpNe;
            isaPkg::opBlez, isaPkg::opBlezl:             cmpOp = ctrlPkg::cmpLez;
            isaPkg::opBgtz, isaPkg::opBgtzl:             cmpOp = ctrlPkg::cmpGtz;
            default:                                     aluOp = ctrlPkg::aluAdd;
        endcase

        branchLikely = branch && op[4]; // likely forms sit at 0x14..0x17
    end

endmodule

/* decoder/immExtend.sv */
`timescale 1ns/1ps

module immExtend (
    input  isaPkg::instrWord_t instr,
    input  logic [ctrlPkg::immKindW-1:0] immKind,
    output logic [isaPkg::wordW-1:0] immediate
);

    always_comb
    begin
        case (immKind)
            ctrlPkg::immSign:   immediate = isaPkg::wordW'($signed(instr.iView.imm16));
            ctrlPkg::immZero:   immediate = isaPkg::wordW'(instr.iView.imm16);
            ctrlPkg::immUpper:  immediate = isaPkg::wordW'({instr.iView.imm16, 16'h0000});
            ctrlPkg::immShamt:  immediate = isaPkg::wordW'(instr.rView.shamt);
            ctrlPkg::immTarget: immediate = isaPkg::wordW'(instr.jView.target26);
            default:            immediate = '0; // immNone
        endcase
    end

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage #(
    parameter int implementLikely = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic inValid,
    output logic inReady,
    input  isaPkg::instrWord_t instruction,
    output logic outValid,
    input  logic outReady,
    output logic [isaPkg::regIdxW-1:0] regRead1,
    output logic [isaPkg::regIdxW-1:0] regRead2,
    output logic [isaPkg::regIdxW-1:0] destReg,
    output logic [ctrlPkg::grfSrcW-1:0] grfSrc,
    output logic [ctrlPkg::aluOpW-1:0] aluOp,
    output logic aluSrc,
    output logic [isaPkg::wordW-1:0] immediate,
    output logic [ctrlPkg::cmpOpW-1:0] cmpOp,
    output logic branch,
    output logic branchLikely,
    output logic absJump,
    output logic jumpFromReg,
    output logic memLoad,
    output logic memStore,
    output logic [ctrlPkg::memWidthW-1:0] memWidth,
    output logic memSignExtend,
    output logic checkOverflow,
    output logic unknownInstr
);

    // unknownInstr is the lsb of the packed word
    localparam int ctrlW = 3 * isaPkg::regIdxW + ctrlPkg::grfSrcW + ctrlPkg::aluOpW
                         + isaPkg::wordW + ctrlPkg::cmpOpW + ctrlPkg::memWidthW + 10;

    logic isSpecial;
    logic isRegimm;
    logic [isaPkg::regIdxW-1:0] pRegRead1, pRegRead2, pDestReg, sRegRead1, sRegRead2;
    logic [isaPkg::regIdxW-1:0] sDestReg, rRegRead1, rDestReg;
    logic [isaPkg::regIdxW-1:0] selRegRead1, selRegRead2, selDestReg;
    logic [ctrlPkg::grfSrcW-1:0] pGrfSrc, sGrfSrc, rGrfSrc, selGrfSrc;
    logic [ctrlPkg::aluOpW-1:0] pAluOp, sAluOp, selAluOp;
    logic [ctrlPkg::immKindW-1:0] pImmKind, sImmKind, rImmKind, selImmKind;
    logic [ctrlPkg::cmpOpW-1:0] pCmpOp, rCmpOp, selCmpOp;
    logic [ctrlPkg::memWidthW-1:0] pMemWidth;
    logic pAluSrc, sAluSrc, pBranch, rBranch, pBranchLikely, rBranchLikely;
    logic pAbsJump, sAbsJump, pJumpFromReg, sJumpFromReg;
    logic pMemLoad, pMemStore, pMemSignExtend;
    logic pCheckOverflow, sCheckOverflow, pUnknown, sUnknown, rUnknown;
    logic selAluSrc, selBranch, selBranchLikely, selAbsJump, selJumpFromReg;
    logic selCheckOverflow, selUnknown;
    logic likelyTrap;
    logic [isaPkg::wordW-1:0] immediateNext;
    logic [ctrlW-1:0] ctrlNext;
    logic [ctrlW-1:0] ctrlReg;

    primaryDecode primaryDecode_inst (
        .instr(instruction), .isSpecial(isSpecial), .isRegimm(isRegimm),
        .regRead1(pRegRead1), .regRead2(pRegRead2), .destReg(pDestReg),
        .grfSrc(pGrfSrc), .aluOp(pAluOp), .aluSrc(pAluSrc), .immKind(pImmKind),
        .cmpOp(pCmpOp), .branch(pBranch), .branchLikely(pBranchLikely),
        .absJump(pAbsJump), .jumpFromReg(pJumpFromReg),
        .memLoad(pMemLoad), .memStore(pMemStore), .memWidth(pMemWidth),
        .memSignExtend(pMemSignExtend), .checkOverflow(pCheckOverflow),
        .unknownInstr(pUnknown)
    );

    specialDecode specialDecode_inst (
        .instr(instruction),
        .regRead1(sRegRead1), .regRead2(sRegRead2), .destReg(sDestReg),
        .grfSrc(sGrfSrc), .aluOp(sAluOp), .aluSrc(sAluSrc), .immKind(sImmKind),
        .absJump(sAbsJump), .jumpFromReg(sJumpFromReg),
        .checkOverflow(sCheckOverflow), .unknownInstr(sUnknown)
    );

    regimmDecode regimmDecode_inst (
        .instr(instruction),
        .regRead1(rRegRead1), .destReg(rDestReg), .grfSrc(rGrfSrc),
        .immKind(rImmKind), .cmpOp(rCmpOp), .branch(rBranch),
        .branchLikely(rBranchLikely), .unknownInstr(rUnknown)
    );

    // primary set is all zero for SPECIAL and REGIMM opcodes
    assign selRegRead1 = isSpecial ? sRegRead1 : isRegimm ? rRegRead1 : pRegRead1;
    assign selRegRead2 = isSpecial ? sRegRead2 : pRegRead2;
    assign selDestReg = isSpecial ? sDestReg : isRegimm ? rDestReg : pDestReg;
    assign selGrfSrc = isSpecial ? sGrfSrc : isRegimm ? rGrfSrc : pGrfSrc;
    assign selAluOp = isSpecial ? sAluOp : pAluOp;
    assign selAluSrc = isSpecial ? sAluSrc : pAluSrc;
    assign selImmKind = isSpecial ? sImmKind : isRegimm ? rImmKind : pImmKind;
    assign selCmpOp = isRegimm ? rCmpOp : pCmpOp;
    assign selBranch = isRegimm ? rBranch : pBranch;
    assign selBranchLikely = isRegimm ? rBranchLikely : pBranchLikely;
    assign selAbsJump = isSpecial ? sAbsJump : pAbsJump;
    assign selJumpFromReg = isSpecial ? sJumpFromReg : pJumpFromReg;
    assign selCheckOverflow = isSpecial ? sCheckOverflow : pCheckOverflow;
    assign selUnknown = isSpecial ? sUnknown : isRegimm ? rUnknown : pUnknown;

    immExtend immExtend_inst (
        .instr(instruction),
        .immKind(selImmKind),
        .immediate(immediateNext)
    );

    // without likely support those branches decode as unknown
    assign likelyTrap = (implementLikely == 0) && selBranchLikely;
    assign ctrlNext = likelyTrap ? ctrlW'(1) :
        {selRegRead1, selRegRead2, selDestReg, selGrfSrc, selAluOp, selAluSrc,
         immediateNext, selCmpOp, selBranch, selBranchLikely, selAbsJump,
         selJumpFromReg, pMemLoad, pMemStore, pMemWidth, pMemSignExtend,
         selCheckOverflow, selUnknown};

    assign inReady = outReady || !outValid;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            outValid <= 1'b0;
            ctrlReg <= '0;
        end
        else if (inValid && inReady)
        begin
            outValid <= 1'b1; // may replace a word leaving this edge
            ctrlReg <= ctrlNext;
        end
        else if (outReady)
            outValid <= 1'b0;
    end

    assign {regRead1, regRead2, destReg, grfSrc, aluOp, aluSrc, immediate, cmpOp,
            branch, branchLikely, absJump, jumpFromReg, memLoad, memStore, memWidth,
            memSignExtend, checkOverflow, unknownInstr} = ctrlReg;

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    initial
    begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        #2 rstN = 1'b1; // released just after the 8th edge
    end

endmodule

/* sim/decodeTb.sv */
`timescale 1ns/1ps

module decodeTb;

    localparam int fieldCount = 19; // instruction plus 18 control fields
    localparam int maxCases = 64;
    localparam int driveDelay = 2;
    localparam string stimPath = "sim/decode_stimulus.txt";

    logic clk;
    logic rstN;
    logic inValid;
    logic inReady;
    isaPkg::instrWord_t instruction;
    logic outValid;
    logic outReady;
    logic [isaPkg::regIdxW-1:0] regRead1;
    logic [isaPkg::regIdxW-1:0] regRead2;
    logic [isaPkg::regIdxW-1:0] destReg;
    logic [ctrlPkg::grfSrcW-1:0] grfSrc;
    logic [ctrlPkg::aluOpW-1:0] aluOp;
    logic aluSrc;
    logic [isaPkg::wordW-1:0] immediate;
    logic [ctrlPkg::cmpOpW-1:0] cmpOp;
    logic branch;
    logic branchLikely;
    logic absJump;
    logic jumpFromReg;
    logic memLoad;
    logic memStore;
    logic [ctrlPkg::memWidthW-1:0] memWidth;
    logic memSignExtend;
    logic checkOverflow;
    logic unknownInstr;

    logic [31:0] stim [0:maxCases-1][0:fieldCount-1];
    logic [31:0] held [1:fieldCount-1];
    string fieldName [1:fieldCount-1] = '{"regRead1", "regRead2", "destReg", "grfSrc",
        "aluOp", "aluSrc", "immediate", "cmpOp", "branch", "branchLikely", "absJump",
        "jumpFromReg", "memLoad", "memStore", "memWidth", "memSignExtend",
        "checkOverflow", "unknownInstr"};
    int caseCount = 0;
    int inIdx = 0; // next instruction to offer
    int outIdx = 0; // next result expected
    int cycleCount = 0;
    int cycleLimit = 100;
    bit stalled = 1'b0;

    clockGen clockGen_inst (.clk(clk), .rstN(rstN));

    decodeStage #(.implementLikely(1)) decodeStage_inst (.*);

    function automatic logic [31:0] observedField(int c);
        case (c)
            1: return 32'(regRead1);
            2: return 32'(regRead2);
            3: return 32'(destReg);
            4: return 32'(grfSrc);
            5: return 32'(aluOp);
            6: return 32'(aluSrc);
            7: return immediate;
            8: return 32'(cmpOp);
            9: return 32'(branch);
            10: return 32'(branchLikely);
            11: return 32'(absJump);
            12: return 32'(jumpFromReg);
            13: return 32'(memLoad);
            14: return 32'(memStore);
            15: return 32'(memWidth);
            16: return 32'(memSignExtend);
            17: return 32'(checkOverflow);
            18: return 32'(unknownInstr);
            default: return '0;
        endcase
    endfunction

    task automatic abortRun(string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkField(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected)
        begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "decoder check failed");
        end
    endtask

    task automatic loadStimulus();
        int fd;
        int n;
        string line;
        logic [31:0] v [0:fieldCount-1];
        fd = $fopen(stimPath, "r");
        if (fd == 0)
            abortRun("cannot open the stimulus file");
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#")
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
                if (n == fieldCount && caseCount < maxCases)
                begin
                    for (int c = 0; c < fieldCount; c++)
                        stim[caseCount][c] = v[c];
                    caseCount++;
                end
                else if (n > 0)
                    abortRun("malformed or surplus line in the stimulus file");
            end
        end
        $fclose(fd);
        if (caseCount == 0)
            abortRun("the stimulus file holds no cases");
    endtask

    task automatic driveInputs();
        outReady = ($urandom % 4) != 0; // low about a quarter of the time
        if (inIdx < caseCount && ($urandom % 8) != 0)
        begin
            inValid = 1'b1;
            instruction = stim[inIdx][0];
        end
        else
        begin
            inValid = 1'b0;
            instruction = '0;
        end
    endtask

    // runs mid-cycle so the values seen here are the ones the next edge sees
    task automatic sampleAndCheck();
        bit pending;
        pending = inIdx > outIdx; // an accepted result waits in the stage
        checkField("outValid", 32'(outValid), 32'(pending));
        if (stalled)
        begin
            for (int c = 1; c < fieldCount; c++)
                checkField(fieldName[c], observedField(c), held[c]);
        end
        checkField("inReady", 32'(inReady), 32'(outReady || !pending));
        if (outValid && outReady)
        begin
            for (int c = 1; c < fieldCount; c++)
                checkField($sformatf("%s[%0d]", fieldName[c], outIdx), observedField(c),
                    stim[outIdx][c]);
            outIdx++;
        end
        stalled = outValid && !outReady;
        for (int c = 1; c < fieldCount; c++)
            held[c] = observedField(c);
        if (inValid && inReady)
            inIdx++;
    endtask

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
            abortRun($sformatf("timeout after %0d cycles with %0d of %0d results seen",
                cycleCount, outIdx, caseCount));
    end

    initial
    begin
        void'($urandom(32'h5e6862cf));
        inValid = 1'b0;
        instruction = '0;
        outReady = 1'b0;
        loadStimulus();
        cycleLimit = 20 * caseCount + 100;
        @(posedge rstN);
        @(negedge clk);
        checkField("outValid", 32'(outValid), 32'd0); // reset state
        for (int c = 1; c < fieldCount; c++)
            checkField(fieldName[c], observedField(c), 32'd0);
        while (outIdx < caseCount)
        begin
            @(posedge clk);
            #driveDelay;
            driveInputs();
            @(negedge clk);
            sampleAndCheck();
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sim/decode_stimulus.txt */
# instr regRead1 regRead2 destReg grfSrc aluOp aluSrc immediate cmpOp branch branchLikely
# absJump jumpFromReg memLoad memStore memWidth memSignExtend checkOverflow unknownInstr (hex)
00221821 01 02 03 1 0 0 00000000 0 0 0 0 0 0 0 0 0 0 0
00a62020 05 06 04 1 0 0 00000000 0 0 0 0 0 0 0 0 0 1 0
01093822 08 09 07 1 1 0 00000000 0 0 0 0 0 0 0 0 0 1 0
01cf6824 0e 0f 0d 1 2 0 00000000 0 0 0 0 0 0 0 0 0 0 0
02328027 11 12 10 1 4 0 00000000 0 0 0 0 0 0 0 0 0 0 0
0064102a 03 04 02 1 9 0 00000000 0 0 0 0 0 0 0 0 0 0 0
00094100 09 00 08 1 6 1 00000004 0 0 0 0 0 0 0 0 0 0 0
000b57c3 0b 00 0a 1 8 1 0000001f 0 0 0 0 0 0 0 0 0 0 0
01073007 07 08 06 1 8 0 00000000 0 0 0 0 0 0 0 0 0 0 0
03e00008 1f 00 00 0 0 0 00000000 0 0 0 1 1 0 0 0 0 0 0
01201009 09 00 02 3 0 0 00000000 0 0 0 1 1 0 0 0 0 0 0
0000000c 00 00 00 0 0 0 00000000 0 0 0 0 0 0 0 0 0 0 1
2023fffc 01 00 03 1 0 1 fffffffc 0 0 0 0 0 0 0 0 0 1 0
2d288000 09 00 08 1 a 1 ffff8000 0 0 0 0 0 0 0 0 0 0 0
316af0f0 0b 00 0a 1 2 1 0000f0f0 0 0 0 0 0 0 0 0 0 0 0
35ac8001 0d 00 0c 1 3 1 00008001 0 0 0 0 0 0 0 0 0 0 0
3c101234 00 00 10 1 0 1 12340000 0 0 0 0 0 0 0 0 0 0 0
8062fff8 03 00 02 2 0 1 fffffff8 0 0 0 0 0 1 0 1 1 1 0
94a40006 05 00 04 2 0 1 00000006 0 0 0 0 0 1 0 2 0 1 0
8ce60100 07 00 06 2 0 1 00000100 0 0 0 0 0 1 0 3 0 1 0
ad490008 0a 09 00 0 0 1 00000008 0 0 0 0 0 0 1 3 0 1 0
1022ffff 01 02 00 0 0 0 ffffffff 1 1 0 0 0 0 0 0 0 0 0
18a00008 05 00 00 0 0 0 00000008 5 1 0 0 0 0 0 0 0 0 0
552afff8 09 0a 00 0 0 0 fffffff8 2 1 1 0 0 0 0 0 0 0 0
5d80ffff 0c 00 00 0 0 0 ffffffff 6 1 1 0 0 0 0 0 0 0 0
04600005 03 00 00 0 0 0 00000005 3 1 0 0 0 0 0 0 0 0 0
04c30001 06 00 00 0 0 0 00000001 4 1 1 0 0 0 0 0 0 0 0
04f00020 07 00 1f 3 0 0 00000020 3 1 0 0 0 0 0 0 0 0 0
05530004 0a 00 1f 3 0 0 00000004 4 1 1 0 0 0 0 0 0 0 0
04281234 00 00 00 0 0 0 00000000 0 0 0 0 0 0 0 0 0 0 1
08abcdef 00 00 00 0 0 0 00abcdef 0 0 0 1 0 0 0 0 0 0 0
0fffffff 00 00 1f 3 0 0 03ffffff 0 0 0 1 0 0 0 0 0 0 0
70221002 00 00 00 0 0 0 00000000 0 0 0 0 0 0 0 0 0 0 1

/* all.f */
common/isaPkg.sv
common/ctrlPkg.sv
decoder/specialDecode.sv
decoder/regimmDecode.sv
decoder/primaryDecode.sv
decoder/immExtend.sv
verilog/decodeStage.sv
sim/clockGen.sv
sim/decodeTb.sv

/* run.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

logFile=sim_run.log

verilator --binary --timing --top-module decodeTb -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VdecodeTb > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$logFile"; then
    echo "run passed"
    exit 0
else
    echo "run failed, pass message not found in $logFile"
    exit 1
fi
